// File: common/l2c_defs.svh
`ifndef L2C_DEFS_SVH
`define L2C_DEFS_SVH

// --------------------------------------------------
// interconnect sizing
// --------------------------------------------------

// requesters: 0 L1D, 1 PTW, 2 IC, 3 ELF loader
`define L2C_NUM_PORTS 4

// request queue entries, also the requester's initial credits
`define L2C_REQ_DEPTH 2

// response queue entries per port
`define L2C_RESP_DEPTH 2

// requester-side response buffer size
`define L2C_RESP_CREDITS 2

// --------------------------------------------------
// backing memory
// --------------------------------------------------
`define L2C_RD_LAT 4
`define L2C_MEM_WORDS 256

`endif

// File: common/l2c_pkg.sv
`include "l2c_defs.svh"

package l2c_pkg;

  // --------------------------------------------------
  // field widths
  // --------------------------------------------------
  typedef logic [$clog2(`L2C_MEM_WORDS)-1:0] l2c_addr_t;
  typedef logic [31:0]                       l2c_data_t;
  typedef logic [$bits(l2c_data_t)/8-1:0]    l2c_be_t;
  typedef logic [3:0]                        l2c_tag_t;
  typedef logic [$clog2(`L2C_NUM_PORTS)-1:0] l2c_port_t;

  typedef enum logic {
    M_XRD = 1'b0,
    M_XWR = 1'b1
  } mem_cmd_t;

  // request as seen on a requester port
  typedef struct packed {
    mem_cmd_t  cmd;
    l2c_addr_t addr;
    l2c_tag_t  tag;
    l2c_data_t data;
    l2c_be_t   byte_en;
  } l2c_req_t;

  // request tagged with its source port on the way to memory
  typedef struct packed {
    l2c_port_t port;
    l2c_req_t  req;
  } l2c_mem_req_t;

  typedef struct packed {
    l2c_tag_t  tag;
    l2c_data_t data;
  } l2c_resp_t;

  // port index lets the router steer the response back
  typedef struct packed {
    l2c_port_t port;
    l2c_resp_t resp;
  } l2c_mem_resp_t;

endpackage

// File: l2c_arbiter/l2c_port_queue.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_port_queue
  import l2c_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_msrh_reset_n,

  input  logic     i_req_valid,
  input  l2c_req_t i_req,
  output logic     o_req_credit,

  output logic     o_head_valid,
  output l2c_req_t o_head,
  input  logic     i_pop
);

  localparam int DEPTH = `L2C_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  l2c_req_t         r_entry [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             w_pop;

  assign o_head_valid = (r_count != '0);
  assign o_head       = r_entry[r_rd_ptr];
  assign w_pop        = i_pop & o_head_valid;

  // pointers and occupancy
  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      r_wr_ptr     <= '0;
      r_rd_ptr     <= '0;
      r_count      <= '0;
      o_req_credit <= 1'b0;
    end else begin
      if (i_req_valid) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      case ({i_req_valid, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
      // one credit back per freed entry, a cycle after the pop
      o_req_credit <= w_pop;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
      r_entry[r_wr_ptr] <= i_req;
    end
  end

endmodule

// File: l2c_arbiter/l2c_arbiter.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_arbiter
  import l2c_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_msrh_reset_n,

  input  logic [`L2C_NUM_PORTS-1:0] i_head_valid,
  input  l2c_req_t                  i_head [`L2C_NUM_PORTS],
  output logic [`L2C_NUM_PORTS-1:0] o_pop,

  input  logic [`L2C_NUM_PORTS-1:0] i_slot_free,

  output logic                      o_mem_req_valid,
  output l2c_mem_req_t              o_mem_req
);

  localparam int NUM   = `L2C_NUM_PORTS;
  localparam int SLOTS = `L2C_RESP_DEPTH;
  localparam int CNT_W = $clog2(SLOTS + 1);

  logic [CNT_W-1:0] r_slot_cnt [NUM];
  logic [NUM-1:0]   w_grant;
  logic             w_any;
  l2c_port_t        w_sel;

  // --------------------------------------------------
  // fixed priority, port 0 first
  // --------------------------------------------------
  always_comb begin
    w_grant = '0;
    w_any   = 1'b0;
    w_sel   = '0;
    for (int p = 0; p < NUM; p++) begin
      if (!w_any && i_head_valid[p] && (r_slot_cnt[p] != '0)) begin
        w_any      = 1'b1;
        w_sel      = l2c_port_t'(p);
        w_grant[p] = 1'b1;
      end
    end
  end

  assign o_pop = w_grant;

  // response slots still free in the router, per port
  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      for (int p = 0; p < NUM; p++) begin
        r_slot_cnt[p] <= CNT_W'(SLOTS);
      end
    end else begin
      for (int p = 0; p < NUM; p++) begin
        case ({w_grant[p], i_slot_free[p]})
          2'b10:   r_slot_cnt[p] <= r_slot_cnt[p] - 1'b1;
          2'b01:   r_slot_cnt[p] <= r_slot_cnt[p] + 1'b1;
          default: r_slot_cnt[p] <= r_slot_cnt[p];
        endcase
      end
    end
  end

  // --------------------------------------------------
  // issue register towards memory
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      o_mem_req_valid <= 1'b0;
    end else begin
      o_mem_req_valid <= w_any;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_any) begin
      o_mem_req.port <= w_sel;
      o_mem_req.req  <= i_head[w_sel];
    end
  end

endmodule

// File: rtl/l2_behavior_mem.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2_behavior_mem
  import l2c_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_msrh_reset_n,

  input  logic          i_mem_req_valid,
  input  l2c_mem_req_t  i_mem_req,

  output logic          o_mem_resp_valid,
  output l2c_mem_resp_t o_mem_resp
);

  localparam int LAT   = `L2C_RD_LAT;
  localparam int WORDS = `L2C_MEM_WORDS;

  l2c_data_t     r_mem [WORDS];
  l2c_data_t     w_rd_word;
  l2c_data_t     w_merged;
  l2c_data_t     w_resp_data;
  logic          w_wr;

  logic [LAT-1:0] r_pipe_valid;
  l2c_mem_resp_t  r_pipe [LAT];

  // --------------------------------------------------
  // array access in the arrival cycle
  // --------------------------------------------------
  assign w_rd_word = r_mem[i_mem_req.req.addr];
  assign w_wr      = i_mem_req_valid & (i_mem_req.req.cmd == M_XWR);

  // byte merge of write data over the stored word
  always_comb begin
    w_merged = w_rd_word;
    for (int b = 0; b < $bits(l2c_be_t); b++) begin
      if (i_mem_req.req.byte_en[b]) begin
        w_merged[b*8 +: 8] = i_mem_req.req.data[b*8 +: 8];
      end
    end
  end

  // a write answers with the word as it stands after the write
  assign w_resp_data = (i_mem_req.req.cmd == M_XWR) ? w_merged : w_rd_word;

  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      for (int i = 0; i < WORDS; i++) begin
        r_mem[i] <= '0;
      end
    end else if (w_wr) begin
      r_mem[i_mem_req.req.addr] <= w_merged;
    end
  end

  // --------------------------------------------------
  // fixed latency pipe, never stalls
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      r_pipe_valid <= '0;
    end else begin
      r_pipe_valid[0] <= i_mem_req_valid;
      for (int s = 1; s < LAT; s++) begin
        r_pipe_valid[s] <= r_pipe_valid[s-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_pipe[0].port      <= i_mem_req.port;
    r_pipe[0].resp.tag  <= i_mem_req.req.tag;
    r_pipe[0].resp.data <= w_resp_data;
    for (int s = 1; s < LAT; s++) begin
      r_pipe[s] <= r_pipe[s-1];
    end
  end

  assign o_mem_resp_valid = r_pipe_valid[LAT-1];
  assign o_mem_resp       = r_pipe[LAT-1];

endmodule

// File: rtl/l2c_resp_router.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_resp_router
  import l2c_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_msrh_reset_n,

  input  logic                      i_mem_resp_valid,
  input  l2c_mem_resp_t             i_mem_resp,

  output logic [`L2C_NUM_PORTS-1:0] o_slot_free,

  output logic [`L2C_NUM_PORTS-1:0] o_resp_valid,
  output l2c_resp_t                 o_resp [`L2C_NUM_PORTS],
  input  logic [`L2C_NUM_PORTS-1:0] i_resp_credit
);

  localparam int DEPTH = `L2C_RESP_DEPTH;
  localparam int CRED  = `L2C_RESP_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(CRED + 1);

  for (genvar p = 0; p < `L2C_NUM_PORTS; p++) begin : g_port
    l2c_resp_t        r_buf [DEPTH];
    logic [PTR_W-1:0] r_wr_ptr;
    logic [PTR_W-1:0] r_rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic [CRD_W-1:0] r_credit;
    logic             r_valid;
    l2c_resp_t        r_resp;
    logic             w_push;
    logic             w_send;

    // steer by the port carried along with the response
    assign w_push = i_mem_resp_valid & (i_mem_resp.port == l2c_port_t'(p));
    // head leaves only while the requester has room for it
    assign w_send = (r_count != '0) & (r_credit != '0);

    always_ff @(posedge i_clk) begin
      if (i_msrh_reset_n) begin
        r_wr_ptr <= '0;
        r_rd_ptr <= '0;
        r_count  <= '0;
        r_credit <= CRD_W'(CRED);
        r_valid  <= 1'b0;
      end else begin
        if (w_push) begin
          r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
        end
        if (w_send) begin
          r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
        end
        case ({w_push, w_send})
          2'b10:   r_count <= r_count + 1'b1;
          2'b01:   r_count <= r_count - 1'b1;
          default: r_count <= r_count;
        endcase
        case ({w_send, i_resp_credit[p]})
          2'b10:   r_credit <= r_credit - 1'b1;
          2'b01:   r_credit <= r_credit + 1'b1;
          default: r_credit <= r_credit;
        endcase
        r_valid <= w_send;
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_push) begin
        r_buf[r_wr_ptr] <= i_mem_resp.resp;
      end
      if (w_send) begin
        r_resp <= r_buf[r_rd_ptr];
      end
    end

    assign o_slot_free[p]  = w_send;
    assign o_resp_valid[p] = r_valid;
    assign o_resp[p]       = r_resp;
  end

endmodule

// File: rtl/l2c_top.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_top
  import l2c_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_msrh_reset_n,

  // requester side, port 0 L1D, 1 PTW, 2 IC, 3 ELF loader
  input  logic [`L2C_NUM_PORTS-1:0] i_req_valid,
  input  l2c_req_t                  i_req [`L2C_NUM_PORTS],
  output logic [`L2C_NUM_PORTS-1:0] o_req_credit,

  output logic [`L2C_NUM_PORTS-1:0] o_resp_valid,
  output l2c_resp_t                 o_resp [`L2C_NUM_PORTS],
  input  logic [`L2C_NUM_PORTS-1:0] i_resp_credit
);

  logic [`L2C_NUM_PORTS-1:0] w_head_valid;
  l2c_req_t                  w_head [`L2C_NUM_PORTS];
  logic [`L2C_NUM_PORTS-1:0] w_pop;
  logic [`L2C_NUM_PORTS-1:0] w_slot_free;

  logic                      w_mem_req_valid;
  l2c_mem_req_t              w_mem_req;
  logic                      w_mem_resp_valid;
  l2c_mem_resp_t             w_mem_resp;

  // --------------------------------------------------
  // request queues
  // --------------------------------------------------
  for (genvar p = 0; p < `L2C_NUM_PORTS; p++) begin : g_port
    l2c_port_queue u_port_queue (
      .i_clk         (i_clk),
      .i_msrh_reset_n(i_msrh_reset_n),
      .i_req_valid   (i_req_valid[p]),
      .i_req         (i_req[p]),
      .o_req_credit  (o_req_credit[p]),
      .o_head_valid  (w_head_valid[p]),
      .o_head        (w_head[p]),
      .i_pop         (w_pop[p])
    );
  end

  l2c_arbiter u_arbiter (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_head_valid   (w_head_valid),
    .i_head         (w_head),
    .o_pop          (w_pop),
    .i_slot_free    (w_slot_free),
    .o_mem_req_valid(w_mem_req_valid),
    .o_mem_req      (w_mem_req)
  );

  l2_behavior_mem u_mem (
    .i_clk           (i_clk),
    .i_msrh_reset_n  (i_msrh_reset_n),
    .i_mem_req_valid (w_mem_req_valid),
    .i_mem_req       (w_mem_req),
    .o_mem_resp_valid(w_mem_resp_valid),
    .o_mem_resp      (w_mem_resp)
  );

  // --------------------------------------------------
  // response side
  // --------------------------------------------------
  l2c_resp_router u_resp_router (
    .i_clk           (i_clk),
    .i_msrh_reset_n  (i_msrh_reset_n),
    .i_mem_resp_valid(w_mem_resp_valid),
    .i_mem_resp      (w_mem_resp),
    .o_slot_free     (w_slot_free),
    .o_resp_valid    (o_resp_valid),
    .o_resp          (o_resp),
    .i_resp_credit   (i_resp_credit)
  );

endmodule

// File: test/l2c_sva.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_sva (
  input logic                      i_clk,
  input logic                      i_msrh_reset_n,
  input logic [`L2C_NUM_PORTS-1:0] i_req_valid,
  // the DUT's o_req_credit and o_resp_valid
  input logic [`L2C_NUM_PORTS-1:0] i_req_credit,
  input logic [`L2C_NUM_PORTS-1:0] i_resp_valid,
  input logic [`L2C_NUM_PORTS-1:0] i_resp_credit,
  input logic [`L2C_NUM_PORTS-1:0] i_slot_free,
  input logic                      i_mem_req_valid,
  input logic                      i_mem_resp_valid
);

  localparam int NUM = `L2C_NUM_PORTS;

  // requests accepted but not yet credited back, per port
  int r_req_out [NUM];
  // responses sent by the router and not yet credited back
  int r_resp_out [NUM];

  always_ff @(posedge i_clk) begin
    if (i_msrh_reset_n) begin
      for (int p = 0; p < NUM; p++) begin
        r_req_out[p]  <= 0;
        r_resp_out[p] <= 0;
      end
    end else begin
      for (int p = 0; p < NUM; p++) begin
        r_req_out[p]  <= r_req_out[p] + int'(i_req_valid[p]) - int'(i_req_credit[p]);
        r_resp_out[p] <= r_resp_out[p] + int'(i_slot_free[p]) - int'(i_resp_credit[p]);
      end
    end
  end

  // --------------------------------------------------
  // reset leaves every valid and pulse low
  // --------------------------------------------------
  a_quiet_after_reset: assert property (@(posedge i_clk)
    i_msrh_reset_n |=> (i_resp_valid == '0 && i_req_credit == '0 && i_slot_free == '0 &&
                        !i_mem_req_valid && !i_mem_resp_valid))
    else $error("a valid or credit output was high in the cycle after reset");

  for (genvar p = 0; p < NUM; p++) begin : g_port
    // a credit never comes back for a request that was not accepted
    a_req_credit_bound: assert property (@(posedge i_clk) disable iff (i_msrh_reset_n)
      (r_req_out[p] >= 0) && (r_req_out[p] <= `L2C_REQ_DEPTH))
      else $error("port %0d request credits out of range, %0d outstanding", p,
                  r_req_out[p]);

    a_send_with_credit: assert property (@(posedge i_clk) disable iff (i_msrh_reset_n)
      i_slot_free[p] |-> (r_resp_out[p] < `L2C_RESP_CREDITS))
      else $error("router sent a response on port %0d without a credit", p);
  end

endmodule

bind l2c_top l2c_sva u_sva (
  .i_clk           (i_clk),
  .i_msrh_reset_n  (i_msrh_reset_n),
  .i_req_valid     (i_req_valid),
  .i_req_credit    (o_req_credit),
  .i_resp_valid    (o_resp_valid),
  .i_resp_credit   (i_resp_credit),
  .i_slot_free     (w_slot_free),
  .i_mem_req_valid (w_mem_req_valid),
  .i_mem_resp_valid(w_mem_resp_valid)
);

// File: test/l2c_tb.sv
`timescale 1ns/1ns
`include "l2c_defs.svh"

module l2c_tb
  import l2c_pkg::*;
();

  localparam int NUM      = `L2C_NUM_PORTS;
  localparam int NUM_STIM = 24;
  localparam int TIMEOUT  = NUM_STIM * 40;

  typedef struct packed {
    l2c_port_t port;
    mem_cmd_t  cmd;
    l2c_addr_t addr;
    l2c_data_t data;
    l2c_be_t   be;
  } stim_t;

  logic           clk;
  logic           msrh_reset_n;
  logic [NUM-1:0] req_valid;
  l2c_req_t       req [NUM];
  logic [NUM-1:0] req_credit;
  logic [NUM-1:0] resp_valid;
  l2c_resp_t      resp [NUM];
  logic [NUM-1:0] resp_credit;

  stim_t       stim [NUM_STIM];
  int          n_loaded;
  l2c_data_t   ref_mem [`L2C_MEM_WORDS];
  l2c_resp_t   exp_resp [NUM][NUM_STIM];
  int          exp_wr [NUM];
  int          exp_rd [NUM];
  int          next_idx [NUM];
  int          req_cred [NUM];
  int          held [NUM];
  int          n_req [NUM];
  int          n_pulse [NUM];
  l2c_tag_t    tag_next [NUM];
  logic [31:0] lfsr_state;
  int          n_issued;
  int          n_resp;
  int          cycle_count;
  int          n_value_err;
  int          n_other_err;
  logic        finished;
  logic        timed_out;

  l2c_top uut (
    .i_clk         (clk),
    .i_msrh_reset_n(msrh_reset_n),
    .i_req_valid   (req_valid),
    .i_req         (req),
    .o_req_credit  (req_credit),
    .o_resp_valid  (resp_valid),
    .o_resp        (resp),
    .i_resp_credit (resp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic add_stim(input int port, input mem_cmd_t cmd, input l2c_addr_t addr,
                          input l2c_data_t data, input l2c_be_t be);
    stim[n_loaded] = '{port: l2c_port_t'(port), cmd: cmd, addr: addr, data: data, be: be};
    n_loaded++;
  endtask

  // --------------------------------------------------
  // stimulus table, each port stays in its own quarter
  // --------------------------------------------------
  task automatic load_table();
    add_stim(0, M_XWR, 8'h0a, 32'h1122_3344, 4'hf);
    add_stim(1, M_XWR, 8'h45, 32'h0bad_f00d, 4'hf);
    add_stim(2, M_XRD, 8'h90, 32'h0, 4'h0);
    add_stim(3, M_XRD, 8'hf0, 32'h0, 4'h0);
    add_stim(0, M_XRD, 8'h0a, 32'h0, 4'h0);
    add_stim(1, M_XWR, 8'h45, 32'h5566_7788, 4'b0101);
    add_stim(2, M_XWR, 8'h91, 32'hcafe_babe, 4'hf);
    add_stim(3, M_XWR, 8'hc1, 32'h8765_4321, 4'hf);
    add_stim(0, M_XWR, 8'h0b, 32'hdead_beef, 4'hf);
    add_stim(1, M_XRD, 8'h45, 32'h0, 4'h0);
    add_stim(2, M_XRD, 8'h91, 32'h0, 4'h0);
    add_stim(3, M_XRD, 8'hc1, 32'h0, 4'h0);
    add_stim(0, M_XRD, 8'h0b, 32'h0, 4'h0);
    add_stim(1, M_XRD, 8'h7f, 32'h0, 4'h0);
    add_stim(2, M_XWR, 8'h91, 32'h0000_00ff, 4'b0001);
    add_stim(3, M_XWR, 8'hc2, 32'hffff_ffff, 4'b0110);
    add_stim(0, M_XRD, 8'h0c, 32'h0, 4'h0);
    add_stim(1, M_XWR, 8'h46, 32'h1234_5678, 4'b0011);
    add_stim(2, M_XRD, 8'h91, 32'h0, 4'h0);
    add_stim(3, M_XRD, 8'hc2, 32'h0, 4'h0);
    add_stim(0, M_XWR, 8'h0a, 32'haabb_ccdd, 4'b1000);
    add_stim(1, M_XRD, 8'h46, 32'h0, 4'h0);
    add_stim(2, M_XRD, 8'h80, 32'h0, 4'h0);
    add_stim(0, M_XRD, 8'h0a, 32'h0, 4'h0);
  endtask

  function automatic int find_next(input int p, input int start);
    for (int i = start; i < NUM_STIM; i++) begin
      if (int'(stim[i].port) == p) begin
        return i;
      end
    end
    return NUM_STIM;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got %0h expected %0h", name, got, exp);
      n_value_err++;
    end
  endtask

  // drive one entry and record the response the memory rules predict
  task automatic issue_next(input int p);
    stim_t     s;
    l2c_data_t word;
    s = stim[next_idx[p]];
    word = ref_mem[s.addr];
    if (s.cmd == M_XWR) begin
      for (int b = 0; b < 4; b++) begin
        if (s.be[b]) begin
          word[b*8 +: 8] = s.data[b*8 +: 8];
        end
      end
      ref_mem[s.addr] = word;
    end
    req[p] <= '{cmd: s.cmd, addr: s.addr, tag: tag_next[p], data: s.data, byte_en: s.be};
    exp_resp[p][exp_wr[p]] = '{tag: tag_next[p], data: word};
    exp_wr[p]++;
    tag_next[p] = tag_next[p] + 4'd1;
    req_cred[p]--;
    n_req[p]++;
    n_issued++;
    next_idx[p] = find_next(p, next_idx[p] + 1);
  endtask

  task automatic drive_inputs();
    logic [NUM-1:0] valid_next;
    logic [NUM-1:0] credit_next;
    logic           b0;
    logic           b1;
    valid_next  = '0;
    credit_next = '0;
    for (int p = 0; p < NUM; p++) begin
      if (next_idx[p] < NUM_STIM && req_cred[p] > 0) begin
        issue_next(p);
        valid_next[p] = 1'b1;
      end
      // free a buffer entry on roughly one cycle in four
      draw_bit(b0);
      draw_bit(b1);
      if (held[p] > 0 && b0 && b1) begin
        held[p]--;
        credit_next[p] = 1'b1;
      end
    end
    req_valid   <= valid_next;
    resp_credit <= credit_next;
  endtask

  task automatic collect_outputs();
    for (int p = 0; p < NUM; p++) begin
      if (req_credit[p]) begin
        req_cred[p]++;
        n_pulse[p]++;
      end
      if (resp_valid[p]) begin
        n_resp++;
        if (held[p] >= `L2C_RESP_CREDITS) begin
          $display("port %0d got a response while its response buffer was full", p);
          n_other_err++;
        end
        held[p]++;
        if (exp_rd[p] == exp_wr[p]) begin
          $display("port %0d got a response that no request asked for", p);
          n_other_err++;
        end else begin
          check_value($sformatf("o_resp[%0d].tag", p), 32'(resp[p].tag),
                      32'(exp_resp[p][exp_rd[p]].tag));
          check_value($sformatf("o_resp[%0d].data", p), resp[p].data,
                      exp_resp[p][exp_rd[p]].data);
          exp_rd[p]++;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    msrh_reset_n = 1'b1;
    req_valid    = '0;
    resp_credit  = '0;
    lfsr_state   = 32'h57a2;
    n_loaded     = 0;
    n_issued     = 0;
    n_resp       = 0;
    cycle_count  = 0;
    n_value_err  = 0;
    n_other_err  = 0;
    finished     = 1'b0;
    timed_out    = 1'b0;
    for (int i = 0; i < `L2C_MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    load_table();
    for (int p = 0; p < NUM; p++) begin
      req[p]      = '0;
      exp_wr[p]   = 0;
      exp_rd[p]   = 0;
      req_cred[p] = `L2C_REQ_DEPTH;
      held[p]     = 0;
      n_req[p]    = 0;
      n_pulse[p]  = 0;
      tag_next[p] = '0;
      next_idx[p] = find_next(p, 0);
    end

    repeat (2) @(posedge clk);
    msrh_reset_n <= 1'b0;

    while (!finished && !timed_out) begin
      @(negedge clk);
      collect_outputs();
      cycle_count++;
      timed_out = (cycle_count >= TIMEOUT);
      finished  = (n_issued == NUM_STIM) && (n_resp == NUM_STIM);
      @(posedge clk);
      drive_inputs();
    end

    if (timed_out && !finished) begin
      $display("timeout after %0d cycles with %0d of %0d responses", cycle_count, n_resp,
               NUM_STIM);
      n_other_err++;
    end else begin
      for (int p = 0; p < NUM; p++) begin
        check_value($sformatf("o_req_credit[%0d] pulse count", p), 32'(n_pulse[p]),
                    32'(n_req[p]));
      end
    end

    $display("%0d value errors, %0d other errors", n_value_err, n_other_err);
    if (n_value_err == 0 && n_other_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/l2c_pkg.sv
l2c_arbiter/l2c_port_queue.sv
l2c_arbiter/l2c_arbiter.sv
rtl/l2_behavior_mem.sv
rtl/l2c_resp_router.sv
rtl/l2c_top.sv
test/l2c_sva.sv
test/l2c_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the l2c testbench with Verilator, run it and scan the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module l2c_tb -f vlog.f \
  -o l2c_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/l2c_sim > sim.log 2>&1 || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "Regression failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL, no result in sim.log"; exit 1; }
